//--- filelist.f
rtl/dcache_pkg.sv
rtl/dcache_port_arbiter.sv
rtl/dcache_bank_ctrl.sv
rtl/dcache_data_bank.sv
rtl/dcache_tag_array.sv
rtl/reuse_sig_table.sv
rtl/dcache_mem.sv
tb/dcache_mem_tb.sv

//--- rtl/dcache_bank_ctrl.sv
////////////////////////////////////////////////////////////
// data bank request steering and word write ack
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_bank_ctrl
  import dcache_pkg::*;
(
  input  cl_wr_t   cl_wr_i,
  input  word_wr_t word_wr_i,
  input  logic     rd_vld_i,
  input  rd_port_t rd_port_i,
  output bank_oh_t bank_req_o,
  output bank_oh_t bank_we_o,
  output set_idx_t [DCACHE_NUM_BANKS-1:0] bank_idx_o,
  output word_be_t [DCACHE_NUM_BANKS-1:0][DCACHE_SET_ASSOC-1:0] bank_be_o,
  output word_t    [DCACHE_NUM_BANKS-1:0][DCACHE_SET_ASSOC-1:0] bank_wdata_o,
  output logic     wr_ack_o
);

  bank_idx_t rd_bank;
  bank_idx_t wr_bank;
  logic      cl_active;
  logic      rd_uses_bank;

  assign rd_bank      = bank_of(rd_port_i.off);
  assign wr_bank      = bank_of(word_wr_i.off);
  assign cl_active    = cl_wr_i.vld & (|cl_wr_i.we);
  // tag-only reads leave the data banks free
  assign rd_uses_bank = rd_vld_i & ~rd_port_i.tag_only;

  // word write refused on a line write or a bank clash with the read
  assign wr_ack_o = (|word_wr_i.req) & ~cl_wr_i.vld &
                    ~(rd_uses_bank & (rd_bank == wr_bank));

  always_comb begin
    bank_req_o = '0;
    bank_we_o  = '0;
    // banks not taken by a line write or a read use the word write index
    for (int k = 0; k < DCACHE_NUM_BANKS; k++) begin
      bank_idx_o[k] = word_wr_i.idx;
    end

    if (cl_active) begin
      // full line write occupies every bank
      bank_req_o = '1;
      bank_we_o  = '1;
      for (int k = 0; k < DCACHE_NUM_BANKS; k++) begin
        bank_idx_o[k] = cl_wr_i.idx;
      end
    end else begin
      if (rd_uses_bank) begin
        bank_req_o[rd_bank] = 1'b1;
        bank_idx_o[rd_bank] = rd_port_i.idx;
      end
      if (wr_ack_o) begin
        bank_req_o[wr_bank] = 1'b1;
        bank_we_o[wr_bank]  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // byte enables and write data per bank and way
  ////////////////////////////////////////////////////////////

  for (genvar k = 0; k < DCACHE_NUM_BANKS; k++) begin : gen_bank
    for (genvar w = 0; w < DCACHE_SET_ASSOC; w++) begin : gen_way
      assign bank_be_o[k][w] =
        (cl_wr_i.vld & cl_wr_i.we[w]) ? cl_wr_i.be[k*8 +: 8] :
        (wr_ack_o & word_wr_i.req[w] & (wr_bank == bank_idx_t'(k))) ? word_wr_i.be :
        '0;

      assign bank_wdata_o[k][w] =
        (cl_wr_i.vld & cl_wr_i.we[w]) ? cl_wr_i.data[k*64 +: 64] : word_wr_i.data;
    end
  end

endmodule

//--- rtl/dcache_data_bank.sv
////////////////////////////////////////////////////////////
// one data bank, a 64-bit word per way and set
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_data_bank
  import dcache_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  set_idx_t                         idx_i,
  input  word_be_t [DCACHE_SET_ASSOC-1:0]  be_i,
  input  word_t    [DCACHE_SET_ASSOC-1:0]  wdata_i,
  output word_t    [DCACHE_SET_ASSOC-1:0]  rdata_o
);

  word_t [DCACHE_SET_ASSOC-1:0] mem_q [DCACHE_NUM_SETS];

  // byte-masked write of every enabled way
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
        for (int b = 0; b < 8; b++) begin
          if (be_i[w][b]) begin
            mem_q[idx_i][w][8*b +: 8] <= wdata_i[w][8*b +: 8];
          end
        end
      end
    end
  end

  // read word held until the next read of this bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

//--- rtl/dcache_mem.sv
////////////////////////////////////////////////////////////
// data cache memory block with read arbitration,
// lookup stage, data banks and reuse predictor
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_mem
  import dcache_pkg::*;
#(
  parameter int unsigned NumPorts = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic     [NumPorts-1:0]  rd_req_i,
  input  rd_port_t [NumPorts-1:0]  rd_port_i,
  input  tag_t     [NumPorts-1:0]  rd_tag_i,
  input  sig_t     [NumPorts-1:0]  rd_sig_i,
  output logic     [NumPorts-1:0]  rd_ack_o,
  output way_oh_t                  rd_vld_bits_o,
  output way_oh_t                  rd_hit_oh_o,
  output word_t                    rd_data_o,
  input  cl_wr_t                   cl_wr_i,
  input  word_wr_t                 word_wr_i,
  output logic                     wr_ack_o,
  output pred_t                    pred_o
);

  localparam int unsigned PortIdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [NumPorts-1:0] rd_prio;
  logic                rd_acked;
  logic [PortIdxW-1:0] gnt_idx;
  rd_port_t            gnt_port;

  // lookup stage
  set_idx_t            lkp_idx_q;
  line_off_t           lkp_off_q;
  logic [PortIdxW-1:0] lkp_port_q;
  logic                cmp_en_q;

  bank_oh_t bank_req;
  bank_oh_t bank_we;
  set_idx_t [DCACHE_NUM_BANKS-1:0]                        bank_idx;
  word_be_t [DCACHE_NUM_BANKS-1:0][DCACHE_SET_ASSOC-1:0]  bank_be;
  word_t    [DCACHE_NUM_BANKS-1:0][DCACHE_SET_ASSOC-1:0]  bank_wdata;
  word_t    [DCACHE_NUM_BANKS-1:0][DCACHE_SET_ASSOC-1:0]  bank_rdata;

  pred_t pred_tbl;

  ////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_prio
    assign rd_prio[p] = rd_port_i[p].prio;
  end

  dcache_port_arbiter #(
    .NumPorts (NumPorts)
  ) i_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (rd_req_i),
    .prio_i    (rd_prio),
    .block_i   (cl_wr_i.vld),
    .gnt_o     (rd_ack_o),
    .gnt_vld_o (rd_acked),
    .gnt_idx_o (gnt_idx)
  );

  assign gnt_port = rd_port_i[gnt_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lkp_idx_q  <= '0;
      lkp_off_q  <= '0;
      lkp_port_q <= '0;
      cmp_en_q   <= 1'b0;
    end else begin
      lkp_idx_q  <= gnt_port.idx;
      lkp_off_q  <= gnt_port.off;
      lkp_port_q <= gnt_idx;
      cmp_en_q   <= rd_acked;
    end
  end

  ////////////////////////////////////////////////////////////
  // data banks
  ////////////////////////////////////////////////////////////

  dcache_bank_ctrl i_bank_ctrl (
    .cl_wr_i      (cl_wr_i),
    .word_wr_i    (word_wr_i),
    .rd_vld_i     (rd_acked),
    .rd_port_i    (gnt_port),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_idx_o   (bank_idx),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata),
    .wr_ack_o     (wr_ack_o)
  );

  for (genvar k = 0; k < DCACHE_NUM_BANKS; k++) begin : gen_bank
    dcache_data_bank i_data_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_req[k]),
      .we_i    (bank_we[k]),
      .idx_i   (bank_idx[k]),
      .be_i    (bank_be[k]),
      .wdata_i (bank_wdata[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  // word of the hit way from the bank the offset points at
  assign rd_data_o = bank_rdata[bank_of(lkp_off_q)][way_oh2idx(rd_hit_oh_o)];

  ////////////////////////////////////////////////////////////
  // tags and predictor
  ////////////////////////////////////////////////////////////

  dcache_tag_array i_tag_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (cl_wr_i.vld ? cl_wr_i.we : {DCACHE_SET_ASSOC{rd_acked}}),
    .we_i       (cl_wr_i.vld),
    .idx_i      (cl_wr_i.vld ? cl_wr_i.idx : gnt_port.idx),
    .wtag_i     (cl_wr_i.tag),
    .wvld_i     (cl_wr_i.vld_bits),
    .cmp_en_i   (cmp_en_q),
    .rd_tag_i   (rd_tag_i[lkp_port_q]),
    .vld_bits_o (rd_vld_bits_o),
    .hit_oh_o   (rd_hit_oh_o)
  );

  reuse_sig_table i_sig_table (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cl_wr_i   (cl_wr_i),
    .hit_oh_i  (rd_hit_oh_o),
    .hit_idx_i (lkp_idx_q),
    .pred_o    (pred_tbl)
  );

  // outside a miss, shct shows the signature of the access in lookup
  always_comb begin
    pred_o = pred_tbl;
    if (!pred_tbl.miss && cmp_en_q) begin
      pred_o.shct = rd_sig_i[lkp_port_q];
    end
  end

endmodule

//--- rtl/dcache_pkg.sv
////////////////////////////////////////////////////////////
// data cache geometry, vector types and port structs
////////////////////////////////////////////////////////////

package dcache_pkg;

  // geometry
  localparam int unsigned DCACHE_SET_ASSOC = 4;
  localparam int unsigned DCACHE_NUM_SETS  = 16;
  localparam int unsigned DCACHE_NUM_BANKS = 2;
  localparam int unsigned DCACHE_TAG_WIDTH = 8;
  localparam int unsigned SIG_WIDTH        = 14;

  typedef logic [DCACHE_TAG_WIDTH-1:0]             tag_t;
  typedef logic [$clog2(DCACHE_NUM_SETS)-1:0]      set_idx_t;
  // byte offset in a line, top bit picks the bank
  typedef logic [$clog2(DCACHE_NUM_BANKS*8)-1:0]   line_off_t;
  typedef logic [$clog2(DCACHE_NUM_BANKS)-1:0]     bank_idx_t;
  typedef logic [63:0]                             word_t;
  typedef logic [7:0]                              word_be_t;
  typedef logic [DCACHE_NUM_BANKS*64-1:0]          line_t;
  typedef logic [DCACHE_NUM_BANKS*8-1:0]           line_be_t;
  typedef logic [DCACHE_SET_ASSOC-1:0]             way_oh_t;
  typedef logic [$clog2(DCACHE_SET_ASSOC)-1:0]     way_idx_t;
  typedef logic [DCACHE_NUM_BANKS-1:0]             bank_oh_t;
  typedef logic [SIG_WIDTH-1:0]                    sig_t;

  ////////////////////////////////////////////////////////////
  // port bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    set_idx_t  idx;
    line_off_t off;
    logic      tag_only;
    logic      prio;
  } rd_port_t;

  typedef struct packed {
    logic      vld;
    way_oh_t   we;
    set_idx_t  idx;
    line_off_t off;
    tag_t      tag;
    line_t     data;
    line_be_t  be;
    way_oh_t   vld_bits;
    logic      sig_we;
    way_idx_t  sig_way;
    sig_t      sig;
  } cl_wr_t;

  typedef struct packed {
    way_oh_t   req;
    set_idx_t  idx;
    line_off_t off;
    word_t     data;
    word_be_t  be;
  } word_wr_t;

  typedef struct packed {
    logic hit;
    logic miss;
    logic outcome;
    sig_t hit_sig;
    sig_t miss_sig;
    sig_t shct;
  } pred_t;

  // bank holding the word at this offset
  function automatic bank_idx_t bank_of(line_off_t off);
    return off[$bits(line_off_t)-1 -: $bits(bank_idx_t)];
  endfunction

  // one-hot way vector to way index
  function automatic way_idx_t way_oh2idx(way_oh_t oh);
    way_idx_t idx;
    idx = '0;
    for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
      if (oh[w]) begin
        idx = way_idx_t'(w);
      end
    end
    return idx;
  endfunction

endpackage

//--- rtl/dcache_port_arbiter.sv
////////////////////////////////////////////////////////////
// read port arbiter with priority masking and round-robin
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_port_arbiter #(
  parameter int unsigned NumPorts = 3,
  localparam int unsigned IdxW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumPorts-1:0] req_i,
  input  logic [NumPorts-1:0] prio_i,
  input  logic                block_i,
  output logic [NumPorts-1:0] gnt_o,
  output logic                gnt_vld_o,
  output logic [IdxW-1:0]     gnt_idx_o
);

  logic [NumPorts-1:0] req_prio;
  logic [NumPorts-1:0] req_masked;
  logic [IdxW-1:0]     rr_d, rr_q;
  logic [IdxW-1:0]     sel_idx;
  logic                sel_found;

  // high priority requests hide all low priority ones
  assign req_prio   = req_i & prio_i;
  assign req_masked = (|req_prio) ? req_prio : req_i;

  // first remaining requester at or after the pointer
  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (rr_q + i) % NumPorts;
      if (!sel_found && req_masked[cand]) begin
        sel_found = 1'b1;
        sel_idx   = IdxW'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (sel_found && !block_i) begin
      gnt_o[sel_idx] = 1'b1;
    end
  end

  assign gnt_vld_o = sel_found & ~block_i;
  assign gnt_idx_o = sel_idx;

  // pointer moves past the winner, wraps at the last port
  assign rr_d = (sel_idx == IdxW'(NumPorts - 1)) ? '0 : sel_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (gnt_vld_o) begin
      rr_q <= rr_d;
    end
  end

endmodule

//--- rtl/dcache_tag_array.sv
////////////////////////////////////////////////////////////
// tag and valid storage with the per-way hit compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_tag_array
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  way_oh_t  req_i,
  input  logic     we_i,
  input  set_idx_t idx_i,
  input  tag_t     wtag_i,
  input  way_oh_t  wvld_i,
  input  logic     cmp_en_i,
  input  tag_t     rd_tag_i,
  output way_oh_t  vld_bits_o,
  output way_oh_t  hit_oh_o
);

  tag_t    [DCACHE_SET_ASSOC-1:0] tag_mem_q [DCACHE_NUM_SETS];
  way_oh_t                        vld_mem_q [DCACHE_NUM_SETS];

  tag_t    [DCACHE_SET_ASSOC-1:0] tag_rd_q;
  way_oh_t                        vld_rd_q;

  ////////////////////////////////////////////////////////////
  // tag storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
      if (req_i[w]) begin
        if (we_i) begin
          tag_mem_q[idx_i][w] <= wtag_i;
        end else begin
          tag_rd_q[w] <= tag_mem_q[idx_i][w];
        end
      end
    end
  end

  // valid bits start cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_mem_q <= '{default: '0};
      vld_rd_q  <= '0;
    end else begin
      for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
        if (req_i[w]) begin
          if (we_i) begin
            vld_mem_q[idx_i][w] <= wvld_i[w];
          end else begin
            vld_rd_q[w] <= vld_mem_q[idx_i][w];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // hit compare against the tag of the following cycle
  ////////////////////////////////////////////////////////////

  assign vld_bits_o = vld_rd_q;

  for (genvar w = 0; w < DCACHE_SET_ASSOC; w++) begin : gen_cmp
    assign hit_oh_o[w] = cmp_en_i & vld_rd_q[w] & (tag_rd_q[w] == rd_tag_i);
  end

endmodule

//--- rtl/reuse_sig_table.sv
////////////////////////////////////////////////////////////
// reuse predictor signature and outcome arrays
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reuse_sig_table
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cl_wr_t   cl_wr_i,
  input  way_oh_t  hit_oh_i,
  input  set_idx_t hit_idx_i,
  output pred_t    pred_o
);

  sig_t    [DCACHE_SET_ASSOC-1:0] sig_q [DCACHE_NUM_SETS];
  way_oh_t                        outcome_q [DCACHE_NUM_SETS];

  way_idx_t hit_way;
  logic     any_hit;

  assign hit_way = way_oh2idx(hit_oh_i);
  assign any_hit = |hit_oh_i;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sig_q     <= '{default: '0};
      outcome_q <= '{default: '0};
    end else begin
      // a refill stores the new signature, outcome not yet reused
      if (cl_wr_i.sig_we) begin
        sig_q[cl_wr_i.idx][cl_wr_i.sig_way]     <= cl_wr_i.sig;
        outcome_q[cl_wr_i.idx][cl_wr_i.sig_way] <= 1'b0;
      end
      // placed last so a hit on the same entry wins
      for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
        if (hit_oh_i[w]) begin
          outcome_q[hit_idx_i][w] <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // predictor outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    pred_o      = '0;
    pred_o.hit  = any_hit;
    pred_o.miss = cl_wr_i.sig_we;

    if (any_hit) begin
      pred_o.hit_sig = sig_q[hit_idx_i][hit_way];
    end

    // old entry being replaced, plus the incoming signature
    if (cl_wr_i.sig_we) begin
      pred_o.miss_sig = sig_q[cl_wr_i.idx][cl_wr_i.sig_way];
      pred_o.outcome  = outcome_q[cl_wr_i.idx][cl_wr_i.sig_way];
      pred_o.shct     = cl_wr_i.sig;
    end
  end

endmodule

//--- tb/dcache_mem_tb.sv
////////////////////////////////////////////////////////////
// testbench for the data cache memory block
// random stimulus checked against a reference model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_mem_tb
  import dcache_pkg::*;
();

  localparam int unsigned NumPorts  = 3;
  localparam int unsigned MaxCycles = 20000;
  localparam int unsigned BankBit   = $bits(line_off_t) - 1;

  logic clk_i = 1'b0;
  logic rst_ni;

  logic     [NumPorts-1:0] rd_req;
  rd_port_t [NumPorts-1:0] rd_port;
  tag_t     [NumPorts-1:0] rd_tag;
  sig_t     [NumPorts-1:0] rd_sig;
  logic     [NumPorts-1:0] rd_ack;
  way_oh_t                 rd_vld_bits;
  way_oh_t                 rd_hit_oh;
  word_t                   rd_data;
  cl_wr_t                  cl_wr;
  word_wr_t                word_wr;
  logic                    wr_ack;
  pred_t                   pred;

  // reference model of the cache contents
  tag_t  m_tag  [DCACHE_NUM_SETS][DCACHE_SET_ASSOC];
  logic  m_vld  [DCACHE_NUM_SETS][DCACHE_SET_ASSOC];
  word_t m_data [DCACHE_NUM_SETS][DCACHE_SET_ASSOC][DCACHE_NUM_BANKS];
  sig_t  m_sig  [DCACHE_NUM_SETS][DCACHE_SET_ASSOC];
  logic  m_out  [DCACHE_NUM_SETS][DCACHE_SET_ASSOC];
  int unsigned rr_ptr;

  int unsigned cycles = 0;
  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned test_cnt;
  int unsigned test_err0;
  string       test_name;

  dcache_mem #(
    .NumPorts (NumPorts)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .rd_port_i     (rd_port),
    .rd_tag_i      (rd_tag),
    .rd_sig_i      (rd_sig),
    .rd_ack_o      (rd_ack),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_data_o     (rd_data),
    .cl_wr_i       (cl_wr),
    .word_wr_i     (word_wr),
    .wr_ack_o      (wr_ack),
    .pred_o        (pred)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("run stopped, no progress after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////

  task automatic compare_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic confirm(input logic cond, input string msg);
    check_cnt++;
    if (cond !== 1'b1) begin
      err_cnt++;
      $display("in test %s, %s", test_name, msg);
    end
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic close_test();
    $display("test %s finished, %0d errors", test_name, err_cnt - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////

  function automatic int find_way(set_idx_t idx, tag_t tag);
    int way;
    way = -1;
    for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
      if (m_vld[idx][w] && m_tag[idx][w] == tag) begin
        way = w;
      end
    end
    return way;
  endfunction

  function automatic way_oh_t model_vld(set_idx_t idx);
    way_oh_t v;
    for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
      v[w] = m_vld[idx][w];
    end
    return v;
  endfunction

  // low tag bits carry the way, so tags in one set never repeat
  function automatic tag_t new_tag(int unsigned way);
    return tag_t'(($urandom << 2) | (way % DCACHE_SET_ASSOC));
  endfunction

  function automatic tag_t absent_tag(set_idx_t idx);
    tag_t tag;
    tag = tag_t'($urandom);
    while (find_way(idx, tag) >= 0) begin
      tag = tag_t'($urandom);
    end
    return tag;
  endfunction

  function automatic line_t random_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  function automatic rd_port_t random_port(set_idx_t idx);
    rd_port_t rp;
    rp.idx      = idx;
    rp.off      = line_off_t'($urandom);
    rp.tag_only = ($urandom % 4 == 0);
    rp.prio     = 1'($urandom);
    return rp;
  endfunction

  function automatic word_wr_t random_word_write();
    word_wr_t ww;
    ww.req  = way_oh_t'(1 << ($urandom % DCACHE_SET_ASSOC));
    ww.idx  = set_idx_t'($urandom);
    ww.off  = line_off_t'($urandom);
    ww.data = {$urandom, $urandom};
    ww.be   = word_be_t'($urandom);
    return ww;
  endfunction

  function automatic logic [NumPorts-1:0] prio_vec(rd_port_t [NumPorts-1:0] ports);
    logic [NumPorts-1:0] v;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      v[i] = ports[i].prio;
    end
    return v;
  endfunction

  // masked request, then first requester from the rotating pointer
  function automatic logic [NumPorts-1:0] expect_grant(logic [NumPorts-1:0] req,
                                                       rd_port_t [NumPorts-1:0] ports,
                                                       logic blocked);
    logic [NumPorts-1:0] hp;
    logic [NumPorts-1:0] cand;
    logic [NumPorts-1:0] gnt;
    int unsigned         p;
    gnt  = '0;
    hp   = req & prio_vec(ports);
    cand = (hp != '0) ? hp : req;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      p = (rr_ptr + i) % NumPorts;
      if (!blocked && gnt == '0 && cand[p]) begin
        gnt[p] = 1'b1;
      end
    end
    return gnt;
  endfunction

  function automatic int unsigned grant_index(logic [NumPorts-1:0] gnt);
    int unsigned idx;
    idx = 0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      if (gnt[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic advance_ptr(input logic [NumPorts-1:0] gnt);
    if (gnt != '0) begin
      rr_ptr = (grant_index(gnt) + 1) % NumPorts;
    end
  endtask

  task automatic merge_word(input word_wr_t ww);
    bank_idx_t k;
    k = ww.off[BankBit];
    for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
      for (int b = 0; b < 8; b++) begin
        if (ww.req[w] && ww.be[b]) begin
          m_data[ww.idx][w][k][8*b +: 8] = ww.data[8*b +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // bus cycles
  ////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    rd_req  = '0;
    rd_port = '0;
    rd_tag  = '0;
    rd_sig  = '0;
    cl_wr   = '0;
    word_wr = '0;
  endtask

  task automatic idle_cycle();
    rd_req  = '0;
    cl_wr   = '0;
    word_wr = '0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_line(input set_idx_t idx, input int unsigned way, input tag_t tag,
                            input logic valid, input line_t data, input sig_t sig);
    cl_wr_t c;
    c          = '0;
    c.vld      = 1'b1;
    c.we       = way_oh_t'(1 << way);
    c.idx      = idx;
    c.off      = line_off_t'($urandom);
    c.tag      = tag;
    c.data     = data;
    c.be       = '1;
    c.vld_bits = valid ? c.we : '0;
    c.sig_we   = 1'b1;
    c.sig_way  = way_idx_t'(way);
    c.sig      = sig;
    cl_wr      = c;
    // competing reads and a word write must be held off
    rd_req     = NumPorts'($urandom);
    word_wr    = random_word_write();
    @(negedge clk_i);
    compare_value("rd_ack_o", '0, rd_ack);
    compare_value("wr_ack_o", 1'b0, wr_ack);
    compare_value("pred_o.miss", 1'b1, pred.miss);
    compare_value("pred_o.hit", 1'b0, pred.hit);
    compare_value("pred_o.outcome", m_out[idx][way], pred.outcome);
    compare_value("pred_o.miss_sig", m_sig[idx][way], pred.miss_sig);
    compare_value("pred_o.shct", sig, pred.shct);
    @(posedge clk_i);
    m_tag[idx][way]     = tag;
    m_vld[idx][way]     = valid;
    m_data[idx][way][0] = data[63:0];
    m_data[idx][way][1] = data[127:64];
    m_sig[idx][way]     = sig;
    m_out[idx][way]     = 1'b0;
    #1;
    cl_wr   = '0;
    rd_req  = '0;
    word_wr = '0;
  endtask

  // ack cycle with an optional word write, then the lookup cycle
  task automatic read_cycle(input logic rd_en, input int unsigned port, input rd_port_t rp,
                            input tag_t tag, input word_wr_t ww);
    logic [NumPorts-1:0] gnt_exp;
    logic                ack_exp;
    int                  way;
    way_oh_t             hit_exp;
    way_oh_t             vld_exp;
    word_t               data_exp;
    sig_t                sig_exp;
    rd_req        = '0;
    rd_req[port]  = rd_en;
    rd_port[port] = rp;
    rd_tag[port]  = ~tag;
    word_wr       = ww;
    gnt_exp  = expect_grant(rd_req, rd_port, 1'b0);
    ack_exp  = (ww.req != '0) &&
               !(rd_en && !rp.tag_only && (rp.off[BankBit] == ww.off[BankBit]));
    way      = find_way(rp.idx, tag);
    hit_exp  = (way >= 0) ? way_oh_t'(1 << way) : '0;
    vld_exp  = model_vld(rp.idx);
    data_exp = (way >= 0) ? m_data[rp.idx][way][rp.off[BankBit]] : '0;
    sig_exp  = (way >= 0) ? m_sig[rp.idx][way] : '0;
    @(negedge clk_i);
    compare_value("rd_ack_o", gnt_exp, rd_ack);
    compare_value("wr_ack_o", ack_exp, wr_ack);
    @(posedge clk_i);
    if (ack_exp) begin
      merge_word(ww);
    end
    advance_ptr(gnt_exp);
    #1;
    rd_req       = '0;
    word_wr      = '0;
    rd_tag[port] = tag;
    rd_sig[port] = sig_t'($urandom);
    @(negedge clk_i);
    if (rd_en) begin
      compare_value("rd_hit_oh_o", hit_exp, rd_hit_oh);
      compare_value("rd_vld_bits_o", vld_exp, rd_vld_bits);
      if (way >= 0 && !rp.tag_only) begin
        compare_value("rd_data_o", data_exp, rd_data);
      end
      compare_value("pred_o.hit", (way >= 0), pred.hit);
      compare_value("pred_o.hit_sig", sig_exp, pred.hit_sig);
      compare_value("pred_o.shct", rd_sig[port], pred.shct);
    end else begin
      compare_value("rd_hit_oh_o", '0, rd_hit_oh);
    end
    compare_value("pred_o.miss", 1'b0, pred.miss);
    @(posedge clk_i);
    if (rd_en && way >= 0) begin
      m_out[rp.idx][way] = 1'b1;
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state();
    open_test("reset_state");
    @(negedge clk_i);
    compare_value("rd_ack_o", '0, rd_ack);
    compare_value("wr_ack_o", 1'b0, wr_ack);
    compare_value("rd_hit_oh_o", '0, rd_hit_oh);
    compare_value("pred_o.hit", 1'b0, pred.hit);
    compare_value("pred_o.miss", 1'b0, pred.miss);
    @(posedge clk_i);
    #1;
    repeat (8) begin
      read_cycle(1'b1, $urandom % NumPorts, random_port(set_idx_t'($urandom)),
                 tag_t'($urandom), '0);
    end
    close_test();
  endtask

  task automatic fill_and_hit();
    set_idx_t    s;
    int unsigned w;
    open_test("fill_and_hit");
    for (int unsigned i = 0; i < DCACHE_NUM_SETS; i++) begin
      for (int unsigned j = 0; j < DCACHE_SET_ASSOC; j++) begin
        write_line(set_idx_t'(i), j, new_tag(j), 1'b1, random_line(), sig_t'($urandom));
      end
    end
    repeat (400) begin
      s = set_idx_t'($urandom);
      w = $urandom % DCACHE_SET_ASSOC;
      // now and then a refill, some of them invalidating
      if ($urandom % 4 == 0) begin
        write_line(s, w, new_tag(w), ($urandom % 8 != 0), random_line(), sig_t'($urandom));
      end else begin
        read_cycle(1'b1, $urandom % NumPorts, random_port(s), m_tag[s][w], '0);
      end
    end
    close_test();
  endtask

  task automatic miss_reads();
    set_idx_t s;
    open_test("miss_reads");
    repeat (80) begin
      s = set_idx_t'($urandom);
      read_cycle(1'b1, $urandom % NumPorts, random_port(s), absent_tag(s), '0);
    end
    close_test();
  endtask

  task automatic word_writes();
    set_idx_t    s;
    int unsigned w;
    rd_port_t    rp;
    open_test("word_writes");
    repeat (500) begin
      s = set_idx_t'($urandom);
      w = $urandom % DCACHE_SET_ASSOC;
      read_cycle($urandom % 4 != 0, $urandom % NumPorts, random_port(s), m_tag[s][w],
                 random_word_write());
    end
    // read every word back
    for (int unsigned i = 0; i < DCACHE_NUM_SETS; i++) begin
      for (int unsigned j = 0; j < DCACHE_SET_ASSOC; j++) begin
        for (int unsigned k = 0; k < DCACHE_NUM_BANKS; k++) begin
          rp              = random_port(set_idx_t'(i));
          rp.tag_only     = 1'b0;
          rp.off[BankBit] = k[0];
          read_cycle(1'b1, $urandom % NumPorts, rp, m_tag[i][j], '0);
        end
      end
    end
    close_test();
  endtask

  task automatic arbitration();
    logic [NumPorts-1:0] gnt_exp;
    logic [NumPorts-1:0] hp;
    int unsigned         prev;
    logic                have_prev;
    logic                same_prio;
    open_test("arbitration");
    same_prio = 1'($urandom);
    // lookups of these ports always miss, so outcomes stay untouched
    for (int unsigned p = 0; p < NumPorts; p++) begin
      rd_port[p]      = random_port(set_idx_t'($urandom));
      rd_port[p].prio = same_prio;
      rd_tag[p]       = absent_tag(rd_port[p].idx);
    end
    have_prev = 1'b0;
    prev      = 0;
    repeat (40) begin
      rd_req  = '1;
      gnt_exp = expect_grant(rd_req, rd_port, 1'b0);
      @(negedge clk_i);
      compare_value("rd_ack_o", gnt_exp, rd_ack);
      if (have_prev) begin
        confirm(rd_ack == (1 << ((prev + 1) % NumPorts)),
                "equal priority ports were not served in rotating order");
      end
      prev      = grant_index(rd_ack);
      have_prev = 1'b1;
      @(posedge clk_i);
      advance_ptr(gnt_exp);
      #1;
    end
    repeat (600) begin
      rd_req = NumPorts'($urandom);
      for (int unsigned p = 0; p < NumPorts; p++) begin
        rd_port[p].prio = 1'($urandom);
      end
      // line write with no way enabled only blocks the reads
      cl_wr     = '0;
      cl_wr.vld = ($urandom % 5 == 0);
      hp        = rd_req & prio_vec(rd_port);
      gnt_exp   = expect_grant(rd_req, rd_port, cl_wr.vld);
      @(negedge clk_i);
      confirm((rd_ack & (rd_ack - 1'b1)) == '0, "rd_ack_o has more than one bit set");
      if (cl_wr.vld) begin
        confirm(rd_ack == '0, "a read was acknowledged during a cacheline write");
      end
      if (hp != '0) begin
        confirm((rd_ack & ~hp) == '0,
                "a low-priority port was granted while a high-priority port requested");
      end
      compare_value("rd_ack_o", gnt_exp, rd_ack);
      compare_value("rd_hit_oh_o", '0, rd_hit_oh);
      @(posedge clk_i);
      advance_ptr(gnt_exp);
      #1;
    end
    idle_cycle();
    clear_inputs();
    close_test();
  endtask

  task automatic predictor_updates();
    set_idx_t    s;
    int unsigned w;
    open_test("predictor_updates");
    repeat (40) begin
      s = set_idx_t'($urandom);
      w = $urandom % DCACHE_SET_ASSOC;
      write_line(s, w, new_tag(w), 1'b1, random_line(), sig_t'($urandom));
      // replaced again with no hit in between
      write_line(s, w, new_tag(w), 1'b1, random_line(), sig_t'($urandom));
      read_cycle(1'b1, $urandom % NumPorts, random_port(s), m_tag[s][w], '0);
      // eviction after the hit shows the reuse
      write_line(s, w, new_tag(w), 1'b1, random_line(), sig_t'($urandom));
    end
    close_test();
  endtask

  initial begin
    void'($urandom(32'h59fe25a0));
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    rr_ptr    = 0;
    for (int i = 0; i < DCACHE_NUM_SETS; i++) begin
      for (int w = 0; w < DCACHE_SET_ASSOC; w++) begin
        m_tag[i][w]     = '0;
        m_vld[i][w]     = 1'b0;
        m_data[i][w][0] = '0;
        m_data[i][w][1] = '0;
        m_sig[i][w]     = '0;
        m_out[i][w]     = 1'b0;
      end
    end
    clear_inputs();
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    reset_state();
    fill_and_hit();
    miss_reads();
    word_writes();
    arbitration();
    predictor_updates();
    idle_cycle();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
